/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_example_soc
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
hdl/soc_pkg.sv
hdl/ahbl_if.sv
hdl/apb_if.sv
hdl/ahbl_splitter.sv
hdl/ahb_sync_sram.sv
hdl/ahbl_to_apb.sv
hdl/uart_regs.sv
hdl/uart_core.sv
hdl/example_soc.sv
test/soc_checker.sv
test/tb_example_soc.sv

/* hdl/ahb_sync_sram.sv */
// Zero-wait single-port SRAM; address bits above the array size alias, contents are not initialised
`timescale 1ns/1ps

module ahb_sync_sram #(
	parameter int sram_depth = 1024
) (
	input  logic clk,
	input  logic arst_n,
	ahbl_if.slave bus
);

	localparam int idx_w = $clog2(sram_depth);
	localparam int lanes = soc_pkg::data_w / 8;

	logic [soc_pkg::data_w-1:0] mem [sram_depth];

	logic             wr_pend;
	logic [idx_w-1:0] addr_q;
	logic [lanes-1:0] be_q;

	// Byte lanes touched by one transfer
	function automatic logic [lanes-1:0] lane_mask(input logic [2:0] size, input logic [1:0] ofs);
		logic [lanes-1:0] mask;
		case (size)
			soc_pkg::hsize_byte: mask = 4'b0001 << ofs;
			soc_pkg::hsize_half: mask = 4'b0011 << {ofs[1], 1'b0};
			soc_pkg::hsize_word: mask = 4'b1111;
			default:             mask = 4'b0000;
		endcase
		return mask;
	endfunction

	// --------------------
	// Address phase capture

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_pend <= 1'b0;
		end else if (bus.hready) begin
			wr_pend <= bus.htrans == soc_pkg::htrans_nonseq && bus.hwrite;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.hready && bus.htrans == soc_pkg::htrans_nonseq) begin
			addr_q <= bus.haddr[idx_w+1:2];
			be_q   <= lane_mask(bus.hsize, bus.haddr[1:0]);
		end
	end

	// --------------------
	// Array access

	// Write lands on the edge that ends the data phase
	always_ff @(posedge clk) begin
		if (wr_pend) begin
			for (int i = 0; i < lanes; i++) begin
				if (be_q[i])
					mem[addr_q][8*i +: 8] <= bus.hwdata[8*i +: 8];
			end
		end
	end

	// Reads see a write from the previous data phase
	assign bus.hrdata      = mem[addr_q];
	assign bus.hready_resp = 1'b1;
	assign bus.hresp       = 1'b0;

endmodule

/* hdl/ahbl_if.sv */
// AHB-Lite subset without HBURST, HPROT or HMASTLOCK; hready is the bus-wide ready seen by slaves
`timescale 1ns/1ps

interface ahbl_if;

	// Address phase and write data, driven towards the slave
	logic [soc_pkg::addr_w-1:0] haddr;
	logic                       hwrite;
	logic [1:0]                 htrans;
	logic [2:0]                 hsize;
	logic [soc_pkg::data_w-1:0] hwdata;
	logic                       hready;

	// Data phase response, driven by the slave
	logic                       hready_resp;
	logic                       hresp;
	logic [soc_pkg::data_w-1:0] hrdata;

	modport master (
		output haddr, hwrite, htrans, hsize, hwdata, hready,
		input  hready_resp, hresp, hrdata
	);

	modport slave (
		input  haddr, hwrite, htrans, hsize, hwdata, hready,
		output hready_resp, hresp, hrdata
	);

endinterface

/* hdl/ahbl_splitter.sv */
// Two-target AHB-Lite decoder; bases must be aligned to decode_mask, misses get a 2-cycle ERROR
`timescale 1ns/1ps

module ahbl_splitter #(
	parameter logic [soc_pkg::addr_w-1:0] sram_base   = 32'h0000_0000,
	parameter logic [soc_pkg::addr_w-1:0] uart_base   = 32'h4000_0000,
	parameter logic [soc_pkg::addr_w-1:0] decode_mask = 32'he000_0000
) (
	input  logic  clk,
	input  logic  arst_n,
	ahbl_if.slave  src,
	ahbl_if.master dst_sram,
	ahbl_if.master dst_apb
);

	localparam logic [1:0] sel_none = 2'd0;
	localparam logic [1:0] sel_sram = 2'd1;
	localparam logic [1:0] sel_apb  = 2'd2;
	localparam logic [1:0] sel_err  = 2'd3;

	logic [1:0] addr_sel;
	logic [1:0] data_sel;
	logic       err_first;

	// --------------------
	// Address phase decode

	always_comb begin
		if (src.htrans != soc_pkg::htrans_nonseq)
			addr_sel = sel_none;
		else if ((src.haddr & decode_mask) == sram_base)
			addr_sel = sel_sram;
		else if ((src.haddr & decode_mask) == uart_base)
			addr_sel = sel_apb;
		else
			addr_sel = sel_err;
	end

	// Address, control and write data fan out; only the hit target sees a transfer
	assign dst_sram.haddr  = src.haddr;
	assign dst_sram.hwrite = src.hwrite;
	assign dst_sram.hsize  = src.hsize;
	assign dst_sram.hwdata = src.hwdata;
	assign dst_sram.hready = src.hready;
	assign dst_sram.htrans = addr_sel == sel_sram ? src.htrans : soc_pkg::htrans_idle;

	assign dst_apb.haddr  = src.haddr;
	assign dst_apb.hwrite = src.hwrite;
	assign dst_apb.hsize  = src.hsize;
	assign dst_apb.hwdata = src.hwdata;
	assign dst_apb.hready = src.hready;
	assign dst_apb.htrans = addr_sel == sel_apb ? src.htrans : soc_pkg::htrans_idle;

	// --------------------
	// Data phase select and error responder

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_sel  <= sel_none;
			err_first <= 1'b0;
		end else begin
			if (src.hready)
				data_sel <= addr_sel;
			// First ERROR cycle holds the bus, second releases it
			err_first <= src.hready && addr_sel == sel_err;
		end
	end

	always_comb begin
		case (data_sel)
			sel_sram: begin
				src.hready_resp = dst_sram.hready_resp;
				src.hresp       = dst_sram.hresp;
				src.hrdata      = dst_sram.hrdata;
			end
			sel_apb: begin
				src.hready_resp = dst_apb.hready_resp;
				src.hresp       = dst_apb.hresp;
				src.hrdata      = dst_apb.hrdata;
			end
			sel_err: begin
				src.hready_resp = !err_first;
				src.hresp       = 1'b1;
				src.hrdata      = '0;
			end
			default: begin
				src.hready_resp = 1'b1;
				src.hresp       = 1'b0;
				src.hrdata      = '0;
			end
		endcase
	end

endmodule

/* hdl/ahbl_to_apb.sv */
// AHB-Lite to APB bridge with fixed 3-cycle data phase; APB slaves must answer without wait states
`timescale 1ns/1ps

module ahbl_to_apb (
	input  logic  clk,
	input  logic  arst_n,
	ahbl_if.slave ahb,
	apb_if.master apb
);

	localparam logic [1:0] st_idle   = 2'd0;
	localparam logic [1:0] st_setup  = 2'd1;
	localparam logic [1:0] st_access = 2'd2;

	logic [1:0]                     state;
	logic                           err_first;
	logic                           err_second;
	logic                           write_q;
	logic [soc_pkg::apb_addr_w-1:0] addr_q;
	logic [soc_pkg::data_w-1:0]     wdata_q;
	logic [soc_pkg::data_w-1:0]     rdata_q;

	// --------------------
	// Transfer controller

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			err_first  <= 1'b0;
			err_second <= 1'b0;
		end else begin
			err_first  <= 1'b0;
			err_second <= err_first;
			case (state)
				st_idle: begin
					if (ahb.hready && ahb.htrans == soc_pkg::htrans_nonseq)
						state <= st_setup;
				end
				st_setup: begin
					state <= st_access;
				end
				default: begin
					// APB completes in the access cycle
					err_first <= apb.pslverr;
					state     <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && ahb.hready && ahb.htrans == soc_pkg::htrans_nonseq) begin
			addr_q  <= ahb.haddr[soc_pkg::apb_addr_w-1:0];
			write_q <= ahb.hwrite;
		end
		// Write data is valid once the AHB data phase has begun
		if (state == st_setup)
			wdata_q <= ahb.hwdata;
		if (state == st_access)
			rdata_q <= apb.prdata;
	end

	// --------------------
	// APB and AHB outputs

	assign apb.psel    = state != st_idle;
	assign apb.penable = state == st_access;
	assign apb.pwrite  = write_q;
	assign apb.paddr   = addr_q;
	assign apb.pwdata  = state == st_setup ? ahb.hwdata : wdata_q;

	assign ahb.hready_resp = state == st_idle && !err_first;
	assign ahb.hresp       = err_first || err_second;
	assign ahb.hrdata      = rdata_q;

endmodule

/* hdl/apb_if.sv */
// APB subset with zero wait states, so no pready is carried
`timescale 1ns/1ps

interface apb_if;

	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [soc_pkg::apb_addr_w-1:0] paddr;
	logic [soc_pkg::data_w-1:0]     pwdata;
	logic [soc_pkg::data_w-1:0]     prdata;
	logic                           pslverr;

	modport master (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pslverr
	);

	modport slave (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pslverr
	);

endinterface

/* hdl/example_soc.sv */
// SRAM at sram_base and UART at uart_base behind one AHB-Lite port; no CPU, debug or reset sync
`timescale 1ns/1ps

module example_soc #(
	parameter int                         sram_depth  = 1024,
	parameter logic [soc_pkg::addr_w-1:0] sram_base   = 32'h0000_0000,
	parameter logic [soc_pkg::addr_w-1:0] uart_base   = 32'h4000_0000,
	parameter logic [soc_pkg::addr_w-1:0] decode_mask = 32'he000_0000,
	parameter int                         div_w       = 16
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [soc_pkg::addr_w-1:0] haddr,
	input  logic                       hwrite,
	input  logic [1:0]                 htrans,
	input  logic [2:0]                 hsize,
	input  logic [soc_pkg::data_w-1:0] hwdata,
	input  logic                       uart_rx,
	output logic [soc_pkg::data_w-1:0] hrdata,
	output logic                       hready,
	output logic                       hresp,
	output logic                       uart_tx,
	output logic                       irq
);

	ahbl_if src_bus ();
	ahbl_if sram_bus ();
	ahbl_if bridge_bus ();
	apb_if  uart_apb ();

	logic [div_w-1:0] div;
	logic             tx_start;
	logic [7:0]       tx_byte;
	logic             tx_busy;
	logic             rx_done;
	logic [7:0]       rx_byte;

	// --------------------
	// Master port

	assign src_bus.haddr  = haddr;
	assign src_bus.hwrite = hwrite;
	assign src_bus.htrans = htrans;
	assign src_bus.hsize  = hsize;
	assign src_bus.hwdata = hwdata;
	// Single master, so the response ready is the bus ready
	assign src_bus.hready = src_bus.hready_resp;

	assign hrdata = src_bus.hrdata;
	assign hready = src_bus.hready_resp;
	assign hresp  = src_bus.hresp;

	// --------------------
	// Fabric and targets

	ahbl_splitter #(
		.sram_base   (sram_base),
		.uart_base   (uart_base),
		.decode_mask (decode_mask)
	) u_splitter (
		.clk      (clk),
		.arst_n   (arst_n),
		.src      (src_bus),
		.dst_sram (sram_bus),
		.dst_apb  (bridge_bus)
	);

	ahb_sync_sram #(
		.sram_depth (sram_depth)
	) u_sram (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (sram_bus)
	);

	ahbl_to_apb u_bridge (
		.clk    (clk),
		.arst_n (arst_n),
		.ahb    (bridge_bus),
		.apb    (uart_apb)
	);

	uart_regs #(
		.div_w (div_w)
	) u_uart_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.apb      (uart_apb),
		.div      (div),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.irq      (irq),
		.tx_busy  (tx_busy),
		.rx_done  (rx_done),
		.rx_byte  (rx_byte)
	);

	uart_core #(
		.div_w (div_w)
	) u_uart_core (
		.clk      (clk),
		.arst_n   (arst_n),
		.div      (div),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.uart_rx  (uart_rx),
		.uart_tx  (uart_tx),
		.tx_busy  (tx_busy),
		.rx_done  (rx_done),
		.rx_byte  (rx_byte)
	);

endmodule

/* hdl/soc_pkg.sv */
// Shared widths, AHB codes and UART register map; only SINGLE NONSEQ transfers are encoded
package soc_pkg;

	// --------------------
	// Bus widths

	localparam int addr_w     = 32;
	localparam int data_w     = 32;
	localparam int apb_addr_w = 16;

	// --------------------
	// AHB-Lite control codes

	// Only IDLE and NONSEQ are generated, no bursts
	localparam logic [1:0] htrans_idle   = 2'b00;
	localparam logic [1:0] htrans_nonseq = 2'b10;

	localparam logic [2:0] hsize_byte = 3'b000;
	localparam logic [2:0] hsize_half = 3'b001;
	localparam logic [2:0] hsize_word = 3'b010;

	// --------------------
	// UART register map

	localparam logic [apb_addr_w-1:0] uart_csr_ofs = 16'h0000;
	localparam logic [apb_addr_w-1:0] uart_div_ofs = 16'h0004;
	localparam logic [apb_addr_w-1:0] uart_tx_ofs  = 16'h0008;
	localparam logic [apb_addr_w-1:0] uart_rx_ofs  = 16'h000c;

	// CSR field positions
	localparam int csr_tx_busy_bit  = 0;
	localparam int csr_rx_valid_bit = 1;
	localparam int csr_irq_en_bit   = 8;

	// Clocks per bit out of reset
	localparam int div_reset = 16;

endpackage

/* hdl/uart_core.sv */
// 8N1 serial engine, div clocks per bit; div below 2 is not supported by the receiver
`timescale 1ns/1ps

module uart_core #(
	parameter int div_w = 16
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic [div_w-1:0] div,
	input  logic             tx_start,
	input  logic [7:0]       tx_byte,
	input  logic             uart_rx,
	output logic             uart_tx,
	output logic             tx_busy,
	output logic             rx_done,
	output logic [7:0]       rx_byte
);

	logic [9:0]       tx_shreg;
	logic [div_w-1:0] tx_cnt;
	logic [3:0]       tx_idx;

	logic [1:0]       rx_sync;
	logic             rx_prev;
	logic             rx_busy;
	logic [div_w-1:0] rx_cnt;
	logic [3:0]       rx_idx;
	logic [7:0]       rx_shreg;
	logic             rx_s;

	// --------------------
	// Transmitter

	// Frame is stop, data LSB first, start; bit 0 is on the line
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_busy  <= 1'b0;
			tx_shreg <= '1;
			tx_cnt   <= '0;
			tx_idx   <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_shreg <= {1'b1, tx_byte, 1'b0};
				tx_busy  <= 1'b1;
				tx_cnt   <= div - 1'b1;
				tx_idx   <= '0;
			end
		end else if (tx_cnt != '0) begin
			tx_cnt <= tx_cnt - 1'b1;
		end else if (tx_idx == 4'd9) begin
			tx_busy <= 1'b0;
		end else begin
			tx_shreg <= {1'b1, tx_shreg[9:1]};
			tx_idx   <= tx_idx + 4'd1;
			tx_cnt   <= div - 1'b1;
		end
	end

	assign uart_tx = tx_shreg[0];

	// --------------------
	// Receiver

	assign rx_s = rx_sync[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			rx_busy <= 1'b0;
			rx_cnt  <= '0;
			rx_idx  <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx};
			rx_prev <= rx_s;
			rx_done <= 1'b0;
			if (!rx_busy) begin
				// Falling edge starts a frame, first sample lands mid start bit
				if (rx_prev && !rx_s) begin
					rx_busy <= 1'b1;
					rx_cnt  <= (div >> 1) - 1'b1;
					rx_idx  <= '0;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= div - 1'b1;
				rx_idx <= rx_idx + 4'd1;
				if (rx_idx == 4'd0 && rx_s)
					rx_busy <= 1'b0;
				else if (rx_idx == 4'd9) begin
					rx_busy <= 1'b0;
					rx_done <= rx_s;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_busy && rx_cnt == '0 && rx_idx != 4'd0 && rx_idx != 4'd9)
			rx_shreg <= {rx_s, rx_shreg[7:1]};
	end

	assign rx_byte = rx_shreg;

endmodule

/* hdl/uart_regs.sv */
// UART registers CSR, DIV, TXDATA and RXDATA; unlisted offsets return pslverr, rx overrun is silent
`timescale 1ns/1ps

module uart_regs #(
	parameter int div_w = 16
) (
	input  logic             clk,
	input  logic             arst_n,
	apb_if.slave             apb,
	output logic [div_w-1:0] div,
	output logic             tx_start,
	output logic [7:0]       tx_byte,
	output logic             irq,
	input  logic             tx_busy,
	input  logic             rx_done,
	input  logic [7:0]       rx_byte
);

	logic       acc;
	logic       wr;
	logic       rd;
	logic       hit_csr;
	logic       hit_div;
	logic       hit_tx;
	logic       hit_rx;
	logic       tx_accept;
	logic       irq_en;
	logic       rx_valid;
	logic [7:0] rx_buf;

	// --------------------
	// Access decode

	assign acc = apb.psel && apb.penable;
	assign wr  = acc && apb.pwrite;
	assign rd  = acc && !apb.pwrite;

	assign hit_csr = apb.paddr == soc_pkg::uart_csr_ofs;
	assign hit_div = apb.paddr == soc_pkg::uart_div_ofs;
	assign hit_tx  = apb.paddr == soc_pkg::uart_tx_ofs;
	assign hit_rx  = apb.paddr == soc_pkg::uart_rx_ofs;

	assign apb.pslverr = acc && !(hit_csr || hit_div || hit_tx || hit_rx);

	// Bytes written while the engine is busy are dropped
	assign tx_accept = wr && hit_tx && !tx_busy && !tx_start;

	// --------------------
	// Register state

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			irq_en   <= 1'b0;
			div      <= div_w'(soc_pkg::div_reset);
			rx_valid <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= tx_accept;
			if (wr && hit_csr)
				irq_en <= apb.pwdata[soc_pkg::csr_irq_en_bit];
			if (wr && hit_div)
				div <= apb.pwdata[div_w-1:0];
			// A new byte wins over a read in the same cycle
			if (rx_done)
				rx_valid <= 1'b1;
			else if (rd && hit_rx)
				rx_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (tx_accept)
			tx_byte <= apb.pwdata[7:0];
		if (rx_done)
			rx_buf <= rx_byte;
	end

	// --------------------
	// Read data

	always_comb begin
		apb.prdata = '0;
		case (apb.paddr)
			soc_pkg::uart_csr_ofs: begin
				apb.prdata[soc_pkg::csr_tx_busy_bit]  = tx_busy;
				apb.prdata[soc_pkg::csr_rx_valid_bit] = rx_valid;
				apb.prdata[soc_pkg::csr_irq_en_bit]   = irq_en;
			end
			soc_pkg::uart_div_ofs: apb.prdata[div_w-1:0] = div;
			soc_pkg::uart_rx_ofs:  apb.prdata[7:0] = rx_buf;
			default:               apb.prdata = '0;
		endcase
	end

	assign irq = irq_en && rx_valid;

endmodule

/* test/soc_checker.sv */
// Compares each finished data phase with its expected response; test names up to 16 characters
`timescale 1ns/1ps

module soc_checker (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [soc_pkg::data_w-1:0] hrdata,
	input  logic                       hready,
	input  logic                       hresp,
	input  logic                       uart_tx,
	input  logic                       irq,
	input  logic                       strobe,
	input  logic [127:0]               test_name,
	input  logic                       check_data,
	input  logic [soc_pkg::data_w-1:0] exp_data,
	input  logic                       exp_err,
	input  logic                       exp_irq,
	output int                         n_run,
	output int                         n_fail
);

	// Idle levels of hready, hresp, uart_tx and irq
	localparam logic [3:0] idle_exp = 4'b1010;

	logic       idle_pending;
	logic [3:0] idle_state;

	assign idle_state = {hready, hresp, uart_tx, irq};

	always @(posedge clk) begin
		if (!arst_n) begin
			n_run        = 0;
			n_fail       = 0;
			idle_pending = 1'b1;
		end else if (idle_pending) begin
			// First edge out of reset
			idle_pending = 1'b0;
			n_run++;
			if (idle_state !== idle_exp) begin
				n_fail++;
				$display("[ERROR] reset_idle: expected 0x%h, actual 0x%h", idle_exp, idle_state);
			end else begin
				$display("[PASS] reset_idle");
			end
		end else if (strobe && hready) begin
			n_run++;
			if (hresp === 1'b1 && !exp_err) begin
				n_fail++;
				$display("[FAIL] %0s: unexpected ERROR response", test_name);
			end else if (hresp !== 1'b1 && exp_err) begin
				n_fail++;
				$display("[FAIL] %0s: ERROR response missing for a bad address", test_name);
			end else if (check_data && !exp_err && hrdata !== exp_data) begin
				n_fail++;
				$display("[ERROR] %0s: expected 0x%08h, actual 0x%08h",
					test_name, exp_data, hrdata);
			end else if (exp_irq && irq !== 1'b1) begin
				n_fail++;
				$display("[FAIL] %0s: irq did not rise", test_name);
			end else if (!exp_irq && irq !== 1'b0) begin
				n_fail++;
				$display("[FAIL] %0s: irq is high where it should be low", test_name);
			end else begin
				$display("[PASS] %0s", test_name);
			end
		end
	end

endmodule

/* test/tb_example_soc.sv */
// Sole AHB-Lite master with one transfer at a time and the UART tx looped back to rx
`timescale 1ns/1ps

module tb_example_soc;

	localparam int clk_period      = 10;
	localparam int uart_div        = 4;
	localparam int irq_wait_cycles = 12 * uart_div;
	localparam int max_steps       = 32;

	localparam logic [1:0] op_write = 2'd0;
	localparam logic [1:0] op_read  = 2'd1;
	localparam logic [1:0] op_wait  = 2'd2;

	localparam logic [2:0] sz_byte = soc_pkg::hsize_byte;
	localparam logic [2:0] sz_half = soc_pkg::hsize_half;
	localparam logic [2:0] sz_word = soc_pkg::hsize_word;

	localparam logic [31:0] csr_addr   = 32'h4000_0000 | 32'(soc_pkg::uart_csr_ofs);
	localparam logic [31:0] div_addr   = 32'h4000_0000 | 32'(soc_pkg::uart_div_ofs);
	localparam logic [31:0] tx_addr    = 32'h4000_0000 | 32'(soc_pkg::uart_tx_ofs);
	localparam logic [31:0] rx_addr    = 32'h4000_0000 | 32'(soc_pkg::uart_rx_ofs);
	localparam logic [31:0] irq_en_val = 32'h1 << soc_pkg::csr_irq_en_bit;
	localparam logic [31:0] busy_val   = 32'h1 << soc_pkg::csr_tx_busy_bit;

	// One row of the stimulus table
	typedef struct packed {
		logic [127:0] name;
		logic [1:0]   op;
		logic [31:0]  addr;
		logic [2:0]   size;
		logic [31:0]  data;
		logic [31:0]  exp;
		logic         exp_err;
		logic         exp_irq;
	} step_t;

	step_t steps [max_steps];
	int    n_steps;
	logic  table_ready;

	logic                       clk;
	logic                       arst_n;
	logic [soc_pkg::addr_w-1:0] haddr;
	logic                       hwrite;
	logic [1:0]                 htrans;
	logic [2:0]                 hsize;
	logic [soc_pkg::data_w-1:0] hwdata;
	logic [soc_pkg::data_w-1:0] hrdata;
	logic                       hready;
	logic                       hresp;
	logic                       irq;
	wire                        uart_line;

	logic         chk_strobe;
	logic [127:0] chk_name;
	logic         chk_data;
	logic [31:0]  chk_exp;
	logic         chk_err;
	logic         chk_irq;
	int           n_run;
	int           n_fail;

	example_soc u_example_soc (
		.clk     (clk),
		.arst_n  (arst_n),
		.haddr   (haddr),
		.hwrite  (hwrite),
		.htrans  (htrans),
		.hsize   (hsize),
		.hwdata  (hwdata),
		.uart_rx (uart_line),
		.hrdata  (hrdata),
		.hready  (hready),
		.hresp   (hresp),
		.uart_tx (uart_line),
		.irq     (irq)
	);

	soc_checker u_checker (
		.clk        (clk),
		.arst_n     (arst_n),
		.hrdata     (hrdata),
		.hready     (hready),
		.hresp      (hresp),
		.uart_tx    (uart_line),
		.irq        (irq),
		.strobe     (chk_strobe),
		.test_name  (chk_name),
		.check_data (chk_data),
		.exp_data   (chk_exp),
		.exp_err    (chk_err),
		.exp_irq    (chk_irq),
		.n_run      (n_run),
		.n_fail     (n_fail)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Word after a narrow write with lanes picked from size and offset
	function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
			input logic [31:0] wdata, input logic [2:0] size, input logic [1:0] ofs);
		logic [31:0] word;
		int          bytes;
		int          first;
		word  = old_word;
		bytes = 1 << size;
		first = int'(ofs) & ~(bytes - 1);
		for (int i = 0; i < 4; i++) begin
			if (i >= first && i < first + bytes)
				word[8*i +: 8] = wdata[8*i +: 8];
		end
		return word;
	endfunction

	task automatic add_step(input logic [127:0] name, input logic [1:0] op,
			input logic [31:0] addr, input logic [2:0] size, input logic [31:0] data,
			input logic [31:0] exp, input logic exp_err, input logic exp_irq);
		steps[n_steps] = '{name, op, addr, size, data, exp, exp_err, exp_irq};
		n_steps++;
	endtask

	// --------------------
	// Stimulus table

	task automatic build_table();
		logic [31:0] w [4];
		logic [7:0]  b;
		logic [15:0] h;
		logic [7:0]  tx0;
		logic [7:0]  tx1;
		logic [31:0] merged;
		for (int i = 0; i < 4; i++)
			w[i] = $urandom;
		b      = 8'($urandom);
		h      = 16'($urandom);
		tx0    = 8'($urandom);
		tx1    = 8'($urandom);
		merged = merge_lanes(32'h1122_3344, {4{b}}, sz_byte, 2'd1);
		merged = merge_lanes(merged, {2{h}}, sz_half, 2'd2);
		n_steps = 0;
		add_step("csr_reset", op_read, csr_addr, sz_word, '0, '0, 1'b0, 1'b0);
		add_step("div_reset", op_read, div_addr, sz_word, '0, 32'(soc_pkg::div_reset), 1'b0, 1'b0);
		add_step("sram_wr0", op_write, 32'h0000_0010, sz_word, w[0], '0, 1'b0, 1'b0);
		add_step("sram_wr1", op_write, 32'h0000_0124, sz_word, w[1], '0, 1'b0, 1'b0);
		add_step("sram_wr2", op_write, 32'h0000_0ffc, sz_word, w[2], '0, 1'b0, 1'b0);
		add_step("sram_wr3", op_write, 32'h0000_0800, sz_word, w[3], '0, 1'b0, 1'b0);
		add_step("sram_rd0", op_read, 32'h0000_0010, sz_word, '0, w[0], 1'b0, 1'b0);
		add_step("sram_rd1", op_read, 32'h0000_0124, sz_word, '0, w[1], 1'b0, 1'b0);
		add_step("sram_rd2", op_read, 32'h0000_0ffc, sz_word, '0, w[2], 1'b0, 1'b0);
		add_step("sram_rd3", op_read, 32'h0000_0800, sz_word, '0, w[3], 1'b0, 1'b0);
		add_step("lane_init", op_write, 32'h0000_0040, sz_word, 32'h1122_3344, '0, 1'b0, 1'b0);
		add_step("lane_byte", op_write, 32'h0000_0041, sz_byte, {4{b}}, '0, 1'b0, 1'b0);
		add_step("lane_half", op_write, 32'h0000_0042, sz_half, {2{h}}, '0, 1'b0, 1'b0);
		add_step("lane_check", op_read, 32'h0000_0040, sz_word, '0, merged, 1'b0, 1'b0);
		add_step("err_unmapped", op_read, 32'h2000_0000, sz_word, '0, '0, 1'b1, 1'b0);
		add_step("err_uart_ofs", op_write, 32'h4000_0010, sz_word, '0, '0, 1'b1, 1'b0);
		add_step("div_write", op_write, div_addr, sz_word, 32'(uart_div), '0, 1'b0, 1'b0);
		add_step("div_read", op_read, div_addr, sz_word, '0, 32'(uart_div), 1'b0, 1'b0);
		add_step("irq_enable", op_write, csr_addr, sz_word, irq_en_val, '0, 1'b0, 1'b0);
		add_step("tx_byte0", op_write, tx_addr, sz_word, {24'h0, tx0}, '0, 1'b0, 1'b0);
		add_step("rx_irq0", op_wait, '0, sz_word, '0, '0, 1'b0, 1'b1);
		add_step("rx_read0", op_read, rx_addr, sz_word, '0, {24'h0, tx0}, 1'b0, 1'b0);
		add_step("tx_byte1", op_write, tx_addr, sz_word, {24'h0, tx1}, '0, 1'b0, 1'b0);
		add_step("csr_busy", op_read, csr_addr, sz_word, '0, irq_en_val | busy_val, 1'b0, 1'b0);
		// Differs from the first byte so a leak shows up in RXDATA
		add_step("tx_dropped", op_write, tx_addr, sz_word, {24'h0, ~tx1}, '0, 1'b0, 1'b0);
		add_step("rx_irq1", op_wait, '0, sz_word, '0, '0, 1'b0, 1'b1);
		add_step("rx_read1", op_read, rx_addr, sz_word, '0, {24'h0, tx1}, 1'b0, 1'b0);
		add_step("rx_quiet", op_wait, '0, sz_word, '0, '0, 1'b0, 1'b0);
		add_step("csr_idle", op_read, csr_addr, sz_word, '0, irq_en_val, 1'b0, 1'b0);
	endtask

	// --------------------
	// Bus driver

	task automatic arm_check(input step_t s);
		chk_name   = s.name;
		chk_data   = s.op == op_read;
		chk_exp    = s.exp;
		chk_err    = s.exp_err;
		chk_irq    = s.exp_irq;
		chk_strobe = 1'b1;
	endtask

	// Starts and ends on a falling edge
	task automatic bus_transfer(input step_t s);
		haddr  = s.addr;
		hwrite = s.op == op_write;
		hsize  = s.size;
		htrans = soc_pkg::htrans_nonseq;
		// Address is taken on the rising edge after a falling edge with hready high
		while (!hready)
			@(negedge clk);
		@(negedge clk);
		htrans = soc_pkg::htrans_idle;
		hwdata = s.data;
		arm_check(s);
		// Data phase ends on the next edge with hready high
		while (!hready)
			@(negedge clk);
		@(negedge clk);
		chk_strobe = 1'b0;
	endtask

	task automatic irq_wait(input step_t s);
		int n;
		n = 0;
		while (n < irq_wait_cycles && !(s.exp_irq && irq)) begin
			@(negedge clk);
			n++;
		end
		arm_check(s);
		@(posedge clk);
		@(negedge clk);
		chk_strobe = 1'b0;
	endtask

	initial begin
		arst_n      = 1'b0;
		haddr       = '0;
		hwrite      = 1'b0;
		htrans      = soc_pkg::htrans_idle;
		hsize       = sz_word;
		hwdata      = '0;
		chk_strobe  = 1'b0;
		chk_name    = '0;
		chk_data    = 1'b0;
		chk_exp     = '0;
		chk_err     = 1'b0;
		chk_irq     = 1'b0;
		table_ready = 1'b0;
		void'($urandom(45149));
		build_table();
		table_ready = 1'b1;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < n_steps; i++) begin
			if (steps[i].op == op_wait)
				irq_wait(steps[i]);
			else
				bus_transfer(steps[i]);
		end
		@(negedge clk);
		$display("Tests run: %0d, passed: %0d, failed: %0d", n_run, n_run - n_fail, n_fail);
		if (n_run != n_steps + 1)
			$display("Checker saw %0d results for %0d tests", n_run, n_steps + 1);
		if (n_fail == 0 && n_run == n_steps + 1) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Ends the run once the budget for the slowest UART rate is used up
	initial begin
		wait (table_ready);
		#(n_steps * (12 * soc_pkg::div_reset + 20) * clk_period);
		$display("Watchdog expired before all tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule
